//--- sim/qbus_golden.txt
# op(0 rd,1 wr,2 byte wr) addr wdata reply_delay(dec, 255 none) exp_rdata exp_err
# exp_rdata is compared on reads and timeouts, unwritten words hold {~idx, idx}
0 0000 0000 0 ff00 0
0 0002 0000 1 fe01 0
0 01fe 0000 2 00ff 0
1 0010 1234 0 0000 0
1 0012 abcd 3 0000 0
1 0014 5a5a 1 0000 0
0 0010 0000 2 1234 0
0 0012 0000 0 abcd 0
0 0014 0000 5 5a5a 0
2 0021 77ee 1 0000 0
0 0020 0000 0 7710 0
2 0020 3388 2 0000 0
0 0020 0000 1 7788 0
1 0030 c3c3 0 0000 0
2 0030 ff11 4 0000 0
2 0031 2299 0 0000 0
0 0031 0000 3 2211 0
1 0100 0f0f 6 0000 0
0 0100 0000 7 0f0f 0
1 0102 f0f0 8 0000 0
0 0102 0000 9 f0f0 0
1 0104 1111 10 0000 0
0 0104 0000 11 1111 0
0 0106 0000 12 7c83 0
0 0180 0000 12 3fc0 0
0 0040 0000 255 ffff 1
0 0040 0000 0 df20 0
1 0042 beef 255 ffff 1
0 0042 0000 1 de21 0
2 0043 aa55 255 ffff 1
0 0042 0000 0 de21 0
1 0044 4321 2 0000 0
0 0044 0000 4 4321 0
2 0045 9900 3 0000 0
0 0044 0000 0 9921 0
0 0012 0000 12 abcd 0

//--- qbus_master.f
common/qbus_pkg.sv
qbus/qbus_cycle_fsm.sv
qbus/qbus_reply_timer.sv
qbus/qbus_addr_data.sv
logic/qbus_master.sv
sim/qbus_checker.sv
sim/tb_qbus_master.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the Qbus master testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -j 0 \
   --top-module tb_qbus_master \
   -f qbus_master.f \
   -o tb_qbus_master

./obj_dir/tb_qbus_master | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
   echo "run failed, see $LOG"
   exit 1
fi
echo "run passed"

//--- sim/tb_qbus_master.sv
/*
 * testbench for the Qbus master: clock, reset, host stimulus from the
 * golden file, a Qbus slave memory model with a settable reply delay
 */
`timescale 1ns/10ps

module tb_qbus_master;
   import qbus_pkg::*;

   localparam TIMEOUT_CYCLES = 16;
   localparam ADDR_SETUP     = 1;
   localparam MAX_TX         = 64;
   localparam NO_REPLY       = 255;     // slave stays silent

   logic        pin_clk;
   logic        rst_n;
   logic        req;
   qbus_req_t   req_data;
   logic        busy;
   logic        done;
   qbus_rsp_t   rsp;

   // terminated bus, released lines read high
   tri1 [15:0]  pin_ad_n;
   tri1         pin_sync_n;
   tri1         pin_din_n;
   tri1         pin_dout_n;
   tri1         pin_wtbt_n;
   tri1         pin_rply_n;

   logic [1:0]  t_op [MAX_TX];
   logic [15:0] t_addr [MAX_TX];
   logic [15:0] t_wdata [MAX_TX];
   int          t_dly [MAX_TX];
   int          n_tx = 0;
   logic        loaded = 1'b0;
   int          tb_err = 0;
   int          err_cnt;
   int          chk_cnt;
   int          done_cnt;

   // slave model state
   logic [15:0] mem [256];
   logic        mem_ready = 1'b0;
   int          reply_delay = 0;
   logic        slv_active = 1'b0;
   logic        slv_replied = 1'b0;
   logic        slv_rply = 1'b0;
   logic        slv_ad_ena = 1'b0;
   logic [15:0] slv_ad = '0;
   logic [15:0] slv_addr = '0;
   logic [15:0] slv_wd;
   int          slv_wait = 0;

   assign pin_ad_n   = slv_ad_ena ? ~slv_ad : 16'hzzzz;
   assign pin_rply_n = slv_rply ? 1'b0 : 1'bz;         // open collector

   qbus_master #(
      .TIMEOUT_CYCLES   (TIMEOUT_CYCLES),
      .ADDR_SETUP       (ADDR_SETUP)
   ) i_dut (
      .pin_clk    (pin_clk),
      .rst_n      (rst_n),
      .req        (req),
      .req_data   (req_data),
      .busy       (busy),
      .done       (done),
      .rsp        (rsp),
      .pin_ad_n   (pin_ad_n),
      .pin_sync_n (pin_sync_n),
      .pin_din_n  (pin_din_n),
      .pin_dout_n (pin_dout_n),
      .pin_wtbt_n (pin_wtbt_n),
      .pin_rply_n (pin_rply_n)
   );

   qbus_checker qbus_checker (
      .pin_clk    (pin_clk),
      .rst_n      (rst_n),
      .busy       (busy),
      .done       (done),
      .rsp        (rsp),
      .pin_ad_n   (pin_ad_n),
      .pin_sync_n (pin_sync_n),
      .pin_din_n  (pin_din_n),
      .pin_dout_n (pin_dout_n),
      .pin_wtbt_n (pin_wtbt_n),
      .pin_rply_n (pin_rply_n),
      .err_cnt    (err_cnt),
      .chk_cnt    (chk_cnt),
      .done_cnt   (done_cnt)
   );

   initial begin
      pin_clk = 1'b0;
      forever #20 pin_clk = ~pin_clk;
   end

   task load_stimulus;
      int              fd;
      logic [1:0]      op_v;
      logic [15:0]     a_v;
      logic [15:0]     w_v;
      logic [15:0]     r_v;
      logic            e_v;
      int              d_v;
      reg [8*96-1:0]   line;
      fd = $fopen("sim/qbus_golden.txt", "r");
      if (fd == 0) begin
         $display("cannot open sim/qbus_golden.txt");
      end else begin
         while (!$feof(fd) && n_tx < MAX_TX) begin
            line = '0;
            if ($fgets(line, fd) > 0 &&
                $sscanf(line, "%h %h %h %d %h %h", op_v, a_v, w_v, d_v, r_v, e_v) == 6) begin
               t_op[n_tx]    = op_v;
               t_addr[n_tx]  = a_v;
               t_wdata[n_tx] = w_v;
               t_dly[n_tx]   = d_v;
               n_tx++;
            end
         end
         $fclose(fd);
      end
   endtask

   task wait_idle;
      while (busy !== 1'b0) begin
         @(posedge pin_clk);
         #5;
      end
   endtask

   task run_transactions;
      int k;
      int gap;
      for (k = 0; k < n_tx; k++) begin
         gap = $urandom % 4;                 // idle gap before the request
         repeat (gap) begin
            @(posedge pin_clk);
            #5;
         end
         wait_idle();
         req_data.op    = qbus_op_e'(t_op[k]);
         req_data.addr  = t_addr[k];
         req_data.wdata = t_wdata[k];
         reply_delay    = t_dly[k];
         req            = 1'b1;
         @(posedge pin_clk);
         #5;
         req            = 1'b0;
      end
      wait_idle();
   endtask

   // word index is addr[8:1], byte lane from addr[0] and WTBT
   always @(posedge pin_clk) begin
      #5;
      if (!mem_ready) begin
         for (int i = 0; i < 256; i++)
            mem[i] = {~i[7:0], i[7:0]};
         mem_ready = 1'b1;
      end
      if (pin_sync_n !== 1'b0) begin
         slv_active  = 1'b0;
         slv_replied = 1'b0;
         slv_rply    = 1'b0;
         slv_ad_ena  = 1'b0;
         slv_wait    = 0;
      end else if (!slv_active) begin
         slv_active = 1'b1;
         slv_addr   = ~pin_ad_n;            // address phase
      end else if (pin_din_n === 1'b0 || pin_dout_n === 1'b0) begin
         if (!slv_replied && reply_delay != NO_REPLY) begin
            if (slv_wait >= reply_delay) begin
               if (pin_din_n === 1'b0) begin
                  slv_ad     = mem[slv_addr[8:1]];
                  slv_ad_ena = 1'b1;
               end else begin
                  slv_wd = ~pin_ad_n;
                  if (pin_wtbt_n !== 1'b0)
                     mem[slv_addr[8:1]] = slv_wd;
                  else if (slv_addr[0])
                     mem[slv_addr[8:1]][15:8] = slv_wd[15:8];
                  else
                     mem[slv_addr[8:1]][7:0] = slv_wd[7:0];
               end
               slv_replied = 1'b1;
               slv_rply    = 1'b1;
            end else begin
               slv_wait++;
            end
         end
      end else if (slv_replied) begin
         slv_rply   = 1'b0;                 // strobe gone, end the reply
         slv_ad_ena = 1'b0;
      end
   end

   initial begin
      wait (loaded === 1'b1 && n_tx > 0);
      #(longint'(n_tx) * (TIMEOUT_CYCLES + 340) * 40);
      $display("watchdog expired before %0d transactions finished", n_tx);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      void'($urandom(32'h3b8e));
      rst_n    = 1'b0;
      req      = 1'b0;
      req_data = '0;
      load_stimulus();
      loaded   = 1'b1;
      repeat (2) @(posedge pin_clk);
      #5;
      rst_n    = 1'b1;
      if (n_tx == 0) begin
         $display("no transactions read from the golden file");
         tb_err++;
      end else begin
         run_transactions();
         repeat (2) @(posedge pin_clk);
         if (done_cnt != n_tx) begin
            $display("only %0d of %0d transactions completed", done_cnt, n_tx);
            tb_err++;
         end
      end
      $display("transactions %0d, checks %0d, checker errors %0d, testbench errors %0d",
               done_cnt, chk_cnt, err_cnt, tb_err);
      if (err_cnt == 0 && tb_err == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

//--- sim/qbus_checker.sv
/*
 * Qbus master checker: compares responses with the golden file,
 * watches the bus lines for protocol errors and counts them
 */
`timescale 1ns/10ps

module qbus_checker (
   input  logic                  pin_clk,
   input  logic                  rst_n,
   input  logic                  busy,
   input  logic                  done,
   input  qbus_pkg::qbus_rsp_t   rsp,
   input  logic [15:0]           pin_ad_n,
   input  logic                  pin_sync_n,
   input  logic                  pin_din_n,
   input  logic                  pin_dout_n,
   input  logic                  pin_wtbt_n,
   input  logic                  pin_rply_n,
   output int                    err_cnt,
   output int                    chk_cnt,
   output int                    done_cnt
);
   import qbus_pkg::*;

   localparam MAX_TX = 64;

   logic [1:0]  g_op [MAX_TX];
   logic [15:0] g_addr [MAX_TX];
   logic [15:0] g_rdata [MAX_TX];
   logic        g_err [MAX_TX];
   int          n_exp = 0;
   int          idx = 0;
   int          errs = 0;
   int          chks = 0;
   int          dones = 0;
   logic        sync_q = 1'b1;
   logic        rply_seen = 1'b0;

   assign err_cnt  = errs;
   assign chk_cnt  = chks;
   assign done_cnt = dones;

   initial begin
      int              fd;
      int              d_v;
      logic [1:0]      op_v;
      logic [15:0]     a_v;
      logic [15:0]     w_v;
      logic [15:0]     r_v;
      logic            e_v;
      reg [8*96-1:0]   line;
      fd = $fopen("sim/qbus_golden.txt", "r");
      if (fd != 0) begin
         while (!$feof(fd) && n_exp < MAX_TX) begin
            line = '0;
            if ($fgets(line, fd) > 0 &&
                $sscanf(line, "%h %h %h %d %h %h", op_v, a_v, w_v, d_v, r_v, e_v) == 6) begin
               g_op[n_exp]    = op_v;
               g_addr[n_exp]  = a_v;
               g_rdata[n_exp] = r_v;
               g_err[n_exp]   = e_v;
               n_exp++;
            end
         end
         $fclose(fd);
      end
   end

   task fault(input string msg);
      $display("checker: %0s at %0d ns", msg, $time);
      errs++;
   endtask

   task compare(input string sig, input logic [15:0] got, input logic [15:0] exp);
      chks++;
      if (got !== exp) begin
         $display("ERR %0d ns %0s got %h expected %h", $time, sig, got, exp);
         errs++;
      end
   endtask

   task check_released;
      if (pin_ad_n !== 16'hffff || pin_sync_n !== 1'b1 || pin_din_n !== 1'b1 ||
          pin_dout_n !== 1'b1 || pin_wtbt_n !== 1'b1)
         fault("bus lines not released while idle");
   endtask

   task check_response;
      dones++;
      if (idx >= n_exp) begin
         fault("done without a pending golden transaction");
      end else begin
         compare("rsp.err", {15'd0, rsp.err}, {15'd0, g_err[idx]});
         if (g_op[idx] == OP_RD || g_err[idx])
            compare("rsp.rdata", rsp.rdata, g_rdata[idx]);
         if (!g_err[idx] && !rply_seen)
            fault("done came before RPLY was seen");
         idx++;
      end
      rply_seen = 1'b0;
   endtask

   // sampled mid-cycle, away from the DUT and driver updates
   always @(negedge pin_clk) begin
      if (!rst_n && (busy !== 1'b0 || done !== 1'b0))
         fault("busy or done high during reset");
      if (busy !== 1'b1 || done === 1'b1)
         check_released();
      if (pin_din_n === 1'b0 && pin_dout_n === 1'b0)
         fault("DIN and DOUT asserted together");
      if (busy === 1'b1 && idx < n_exp) begin
         if (pin_sync_n === 1'b0 && sync_q !== 1'b0) begin
            compare("AD at SYNC", ~pin_ad_n, g_addr[idx]);
            compare("WTBT at SYNC", {15'd0, ~pin_wtbt_n}, {15'd0, g_op[idx] != OP_RD});
         end
         if (pin_dout_n === 1'b0)
            compare("WTBT at DOUT", {15'd0, ~pin_wtbt_n}, {15'd0, g_op[idx] == OP_WRB});
         if (pin_rply_n === 1'b0)
            rply_seen = 1'b1;
      end
      if (done === 1'b1)
         check_response();
      sync_q = pin_sync_n;
   end

endmodule

//--- logic/qbus_master.sv
/*
 * Qbus bus master top: pin inversion and tristate drivers around
 * the cycle FSM, reply timer and address/data path
 */
`timescale 1ns/10ps

module qbus_master #(
   parameter TIMEOUT_CYCLES = 16,   // RPLY wait limit
   parameter ADDR_SETUP     = 1     // address cycles before SYNC
)(
   input  logic                  pin_clk,      // bus clock
   input  logic                  rst_n,
   input  logic                  req,          // host request strobe
   input  qbus_pkg::qbus_req_t   req_data,
   output logic                  busy,
   output logic                  done,
   output qbus_pkg::qbus_rsp_t   rsp,
                                               //
   inout  wire [15:0]            pin_ad_n,     // inverted address/data
   inout  wire                   pin_sync_n,   // address strobe
   inout  wire                   pin_din_n,    // data input strobe
   inout  wire                   pin_dout_n,   // data output strobe
   inout  wire                   pin_wtbt_n,   // write/byte status
   input  wire                   pin_rply_n    // slave reply
);
   import qbus_pkg::*;

   qbus_ctrl_t    ctrl;
   qbus_phase_e   ad_phase;
   logic          load;
   logic          capture;
   logic          wait_rply;
   logic          expired;
   logic          ad_ena;
   logic [15:0]   ad_out;

   // lines are active low, released when not owned
   assign pin_ad_n   = ad_ena        ? ~ad_out    : 16'hZZZZ;
   assign pin_sync_n = ctrl.ctrl_ena ? ~ctrl.sync : 1'bZ;
   assign pin_din_n  = ctrl.ctrl_ena ? ~ctrl.din  : 1'bZ;
   assign pin_dout_n = ctrl.ctrl_ena ? ~ctrl.dout : 1'bZ;
   assign pin_wtbt_n = ctrl.ctrl_ena ? ~ctrl.wtbt : 1'bZ;

   qbus_cycle_fsm #(
      .ADDR_SETUP       (ADDR_SETUP),
      .TIMEOUT_CYCLES   (TIMEOUT_CYCLES)
   ) i_cycle (
      .pin_clk    (pin_clk),
      .rst_n      (rst_n),
      .req        (req),
      .req_data   (req_data),
      .rply       (~pin_rply_n),
      .expired    (expired),
      .busy       (busy),
      .done       (done),
      .load       (load),
      .capture    (capture),
      .wait_rply  (wait_rply),
      .ad_phase   (ad_phase),
      .ctrl       (ctrl)
   );

   qbus_reply_timer #(
      .TIMEOUT_CYCLES   (TIMEOUT_CYCLES)
   ) i_timer (
      .pin_clk    (pin_clk),
      .rst_n      (rst_n),
      .wait_rply  (wait_rply),
      .expired    (expired)
   );

   qbus_addr_data i_addr_data (
      .pin_clk    (pin_clk),
      .rst_n      (rst_n),
      .load       (load),
      .req_data   (req_data),
      .ad_phase   (ad_phase),
      .capture    (capture),
      .ad_in      (~pin_ad_n),
      .timeout    (expired),
      .ad_out     (ad_out),
      .ad_ena     (ad_ena),
      .rsp        (rsp)
   );

endmodule

//--- qbus/qbus_addr_data.sv
/*
 * Qbus address/data path: request latch, AD output mux and enable
 * per phase, read data capture and timeout response
 */
`timescale 1ns/10ps

module qbus_addr_data (
   input  logic                     pin_clk,
   input  logic                     rst_n,
   input  logic                     load,       // request accepted
   input  qbus_pkg::qbus_req_t      req_data,
   input  qbus_pkg::qbus_phase_e    ad_phase,
   input  logic                     capture,    // read reply seen
   input  logic [15:0]              ad_in,      // AD lines, active high
   input  logic                     timeout,    // timer expired
   output logic [15:0]              ad_out,
   output logic                     ad_ena,
   output qbus_pkg::qbus_rsp_t      rsp
);
   import qbus_pkg::*;

   qbus_req_t req_q;

   always_ff @(posedge pin_clk) begin
      if (load)
         req_q <= req_data;
   end

   // byte writes put the word as is, the slave picks the lane by addr[0]
   always_comb begin
      case (ad_phase)
         AD_ADDR: begin
            ad_out = req_q.addr;
            ad_ena = 1'b1;
         end
         AD_DATA: begin
            ad_out = req_q.wdata;
            ad_ena = (req_q.op != OP_RD);   // slave drives AD on reads
         end
         default: begin
            ad_out = req_q.addr;
            ad_ena = 1'b0;
         end
      endcase
   end

   always_ff @(posedge pin_clk or negedge rst_n) begin
      if (!rst_n) begin
         rsp <= '0;
      end else if (timeout) begin
         rsp.rdata <= '1;                   // bus error pattern
         rsp.err   <= 1'b1;
      end else if (capture) begin
         rsp.rdata <= ad_in;
         rsp.err   <= 1'b0;
      end else if (load) begin
         rsp.err   <= 1'b0;                 // writes keep last rdata
      end
   end

   // FSM never samples a reply in the timeout cycle
   a_cap_tmo: assert property (@(posedge pin_clk) disable iff (!rst_n)
      !(capture && timeout));

endmodule

//--- qbus/qbus_reply_timer.sv
/*
 * RPLY wait timer, counts cycles while the FSM waits for a reply
 * and pulses expired once at the limit
 */
`timescale 1ns/10ps

module qbus_reply_timer #(
   parameter TIMEOUT_CYCLES = 16    // wait cycles before bus timeout
)(
   input  logic   pin_clk,
   input  logic   rst_n,
   input  logic   wait_rply,        // count enable, clears when low
   output logic   expired           // one-cycle timeout strobe
);

   localparam CNT_W = $clog2(TIMEOUT_CYCLES + 1);

   logic [CNT_W-1:0] cnt;

   always_ff @(posedge pin_clk or negedge rst_n) begin
      if (!rst_n)
         cnt <= '0;
      else if (!wait_rply)
         cnt <= '0;
      else if (cnt != CNT_W'(TIMEOUT_CYCLES))
         cnt <= cnt + 1'b1;         // saturates at limit
   end

   // fires in the TIMEOUT_CYCLES-th wait cycle, silent once saturated
   assign expired = wait_rply && (cnt == CNT_W'(TIMEOUT_CYCLES - 1));

   a_exp_wait: assert property (@(posedge pin_clk) disable iff (!rst_n)
      expired |-> wait_rply);

   a_exp_once: assert property (@(posedge pin_clk) disable iff (!rst_n)
      expired |=> !expired);

endmodule

//--- qbus/qbus_cycle_fsm.sv
/*
 * Qbus master cycle FSM: address setup, SYNC, DIN/DOUT data phase,
 * RPLY wait with timeout and release, plus a two-flop RPLY synchronizer
 */
`timescale 1ns/10ps

module qbus_cycle_fsm #(
   parameter ADDR_SETUP     = 1,    // address cycles before SYNC
   parameter TIMEOUT_CYCLES = 16    // RPLY wait limit
)(
   input  logic                     pin_clk,
   input  logic                     rst_n,
   input  logic                     req,        // host strobe
   input  qbus_pkg::qbus_req_t      req_data,
   input  logic                     rply,       // raw RPLY, active high
   input  logic                     expired,    // from reply timer
   output logic                     busy,
   output logic                     done,
   output logic                     load,       // latch request in data block
   output logic                     capture,    // sample read data
   output logic                     wait_rply,  // timer runs while high
   output qbus_pkg::qbus_phase_e    ad_phase,
   output qbus_pkg::qbus_ctrl_t     ctrl
);
   import qbus_pkg::*;

   localparam SETUP_W = (ADDR_SETUP > 1) ? $clog2(ADDR_SETUP) : 1;

   typedef enum logic [2:0] {
      IDLE,
      ADDR,
      SYNC,
      DATA,
      WAIT_RPLY,
      WAIT_NEG,
      DONE
   } state_e;

   state_e               state;
   logic [SETUP_W-1:0]   set_cnt;      // address setup cycles
   qbus_op_e             op_q;
   logic                 rply_m;
   logic                 rply_s;       // synchronized RPLY
   logic                 is_wr;
   logic                 is_byte;

   assign is_wr   = (op_q != OP_RD);
   assign is_byte = (op_q == OP_WRB);

   // RPLY comes from another board, two flops before use
   always_ff @(posedge pin_clk or negedge rst_n) begin
      if (!rst_n) begin
         rply_m <= 1'b0;
         rply_s <= 1'b0;
      end else begin
         rply_m <= rply;
         rply_s <= rply_m;
      end
   end

   always_ff @(posedge pin_clk) begin
      if (load)
         op_q <= req_data.op;
   end

   always_ff @(posedge pin_clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= IDLE;
         set_cnt <= '0;
      end else begin
         case (state)
            IDLE: begin
               set_cnt <= '0;
               if (req)
                  state <= ADDR;
            end
            ADDR: begin
               set_cnt <= set_cnt + 1'b1;
               if (set_cnt == SETUP_W'(ADDR_SETUP - 1))
                  state <= SYNC;
            end
            SYNC:      state <= DATA;
            DATA:      state <= WAIT_RPLY;
            WAIT_RPLY: begin
               if (expired)                 // abort, release everything
                  state <= DONE;
               else if (rply_s)
                  state <= WAIT_NEG;
            end
            WAIT_NEG: begin
               if (!rply_s)
                  state <= DONE;
            end
            default:   state <= IDLE;       // DONE
         endcase
      end
   end

   assign load      = (state == IDLE) && req;
   assign busy      = (state != IDLE);
   assign done      = (state == DONE);
   assign wait_rply = (state == WAIT_RPLY);
   assign capture   = wait_rply && rply_s && !expired && !is_wr;

   always_comb begin
      ctrl     = '0;
      ad_phase = AD_OFF;
      case (state)
         ADDR, SYNC: begin
            ctrl.ctrl_ena = 1'b1;
            ctrl.sync     = (state == SYNC);
            ctrl.wtbt     = is_wr;          // write status in address phase
            ad_phase      = AD_ADDR;
         end
         DATA, WAIT_RPLY: begin
            ctrl.ctrl_ena = 1'b1;
            ctrl.sync     = 1'b1;
            ctrl.din      = !is_wr;
            ctrl.dout     = is_wr;
            ctrl.wtbt     = is_byte;        // byte status in data phase
            ad_phase      = AD_DATA;
         end
         WAIT_NEG: begin
            ctrl.ctrl_ena = 1'b1;
            ctrl.sync     = 1'b1;           // strobe dropped, hold SYNC
            ctrl.wtbt     = is_byte;
            ad_phase      = AD_DATA;
         end
         default: ;
      endcase
   end

   a_strobe_excl: assert property (@(posedge pin_clk) disable iff (!rst_n)
      !(ctrl.din && ctrl.dout));

   a_strobe_sync: assert property (@(posedge pin_clk) disable iff (!rst_n)
      (ctrl.din || ctrl.dout) |-> ctrl.sync);

   // timer must end every RPLY wait in time
   a_wait_bound: assert property (@(posedge pin_clk) disable iff (!rst_n)
      $rose(wait_rply) |-> ##[1:TIMEOUT_CYCLES] !wait_rply);

endmodule

//--- common/qbus_pkg.sv
/*
 * shared Qbus master types: bus opcodes, AD phase selector,
 * host request and response structs, active-high bus control lines
 */
package qbus_pkg;

   // host operations, byte lane of OP_WRB picked by addr[0]
   typedef enum logic [1:0] {
      OP_RD  = 2'd0,    // word read, DIN cycle
      OP_WR  = 2'd1,    // word write, DOUT cycle
      OP_WRB = 2'd2     // byte write, DOUT with WTBT
   } qbus_op_e;

   // what the AD lines carry
   typedef enum logic [1:0] {
      AD_OFF  = 2'd0,   // released
      AD_ADDR = 2'd1,   // address phase
      AD_DATA = 2'd2    // write data, or released on reads
   } qbus_phase_e;

   // host request, 34 bits
   typedef struct packed {
      qbus_op_e    op;
      logic [15:0] addr;
      logic [15:0] wdata;
   } qbus_req_t;

   // host response, 17 bits
   typedef struct packed {
      logic [15:0] rdata;   // all ones after a timeout
      logic        err;     // no RPLY in time
   } qbus_rsp_t;

   // control lines before inversion, 5 bits
   typedef struct packed {
      logic sync;
      logic din;
      logic dout;
      logic wtbt;
      logic ctrl_ena;       // own SYNC, DIN, DOUT, WTBT
   } qbus_ctrl_t;

endpackage
